/* bench/fabric_model.svh */
	// --------------------
	// reference model
	// --------------------
	// one call per clock in request order keeps the state
	// in step with the DUT target stage

	soc_bus_pkg::data_t m_scr [SCR_WORDS];
	logic [SEMA_COUNT-1:0] m_sema;
	soc_bus_pkg::led_t m_led;
	soc_bus_pkg::rst_vec_t m_vec;
	soc_bus_pkg::clken_t m_clken;
	// pulse counter that is saturated when idle
	int m_cnt;

	function automatic void reset_model();
		m_sema = '0;
		m_led = '0;
		m_vec = '0;
		m_cnt = RST_PULSE_LEN;
		// node clocks 1 and 2 on
		m_clken = 3'b110;
	endfunction

	// live reset vector while the pulse runs
	function automatic soc_bus_pkg::rst_vec_t live_rsts();
		if (m_cnt < RST_PULSE_LEN)
			return m_vec;
		return '0;
	endfunction

	// address decode against the fixed map
	function automatic soc_bus_pkg::tgt_e addr_target(input soc_bus_pkg::addr_t a);
		logic io;
		io = a[31:20] == 12'hFD0;
		if (a[31:24] == 8'hFF)
			return soc_bus_pkg::TGT_SCR;
		if (io && a[19:8] == 12'hFFF)
			return soc_bus_pkg::TGT_LED;
		if (io && a[19:8] == 12'hFFC)
			return soc_bus_pkg::TGT_RST;
		if (io && a[19:16] == 4'h5)
			return soc_bus_pkg::TGT_SEMA;
		return soc_bus_pkg::TGT_NONE;
	endfunction

	// expected response for one request before the state update
	function automatic soc_bus_pkg::bus_resp_t step_model(input soc_bus_pkg::bus_req_t r);
		soc_bus_pkg::bus_resp_t e;
		soc_bus_pkg::data_t rd_led;
		soc_bus_pkg::data_t rd_rst;
		soc_bus_pkg::word_t word;
		logic [3:0] lsel;
		int lane;
		int idx;
		e = '0;
		e.ack = r.stb;
		e.tid = r.tid;
		e.adr = r.padr;
		lane = int'(r.padr[3:2]);
		word = r.data[lane*32 +: 32];
		lsel = r.sel[lane*4 +: 4];
		// io reads see the registers before this cycle's update
		rd_led = {4{24'd0, m_led}};
		rd_rst = {4{13'd0, m_clken, live_rsts()}};
		if (m_cnt < RST_PULSE_LEN)
			m_cnt++;
		if (!r.stb)
			return e;
		case (addr_target(r.padr))
			soc_bus_pkg::TGT_SCR: begin
				idx = int'(r.padr[31:4]) % SCR_WORDS;
				if (r.we) begin
					for (int i = 0; i < 16; i++) begin
						if (r.sel[i])
							m_scr[idx][i*8 +: 8] = r.data[i*8 +: 8];
					end
				end
				else
					e.dat = m_scr[idx];
			end
			soc_bus_pkg::TGT_SEMA: begin
				idx = int'(r.padr[31:2]) % SEMA_COUNT;
				if (r.we)
					m_sema[idx] = 1'b0;
				else begin
					// test-and-set
					e.dat = {4{31'd0, m_sema[idx]}};
					m_sema[idx] = 1'b1;
				end
			end
			soc_bus_pkg::TGT_LED: begin
				if (r.we)
					m_led = word[7:0];
				else
					e.dat = rd_led;
			end
			soc_bus_pkg::TGT_RST: begin
				if (r.we) begin
					if (|lsel[1:0]) begin
						m_vec = word[15:0];
						m_cnt = 0;
					end
					if (|lsel[3:2])
						m_clken = word[18:16];
				end
				else
					e.dat = rd_rst;
			end
			default: begin
				// unmapped
				e.err = 1'b1;
				e.dat = '1;
			end
		endcase
		return e;
	endfunction

/* bench/soc_io_fabric_tb.sv */
`timescale 1ns/1ns

module soc_io_fabric_tb;

	localparam int SCR_WORDS = 64;
	localparam int SEMA_COUNT = 32;
	localparam int RST_PULSE_LEN = 64;
	localparam int TICK_PERIOD = 40;
	localparam int TICK_START = 5;
	localparam int TICK_END = 10;
	localparam int NUM_RAND = 1500;
	localparam int NUM_TXN = SCR_WORDS + NUM_RAND;
	// idle tail covers the pipeline and one full reset pulse
	localparam int DRAIN = RST_PULSE_LEN + 8;
	localparam int WATCHDOG_NS = (NUM_TXN * 10 + 200) * 20;

	logic node_clk;
	logic rst;
	soc_bus_pkg::bus_req_t req_i;
	soc_bus_pkg::bus_resp_t resp_o;
	soc_bus_pkg::led_t led_o;
	soc_bus_pkg::rst_vec_t rsts_o;
	soc_bus_pkg::clken_t clken_o;
	logic tick_irq_o;

	int errors;
	int cyc;
	soc_bus_pkg::bus_resp_t exp_q[$];
	int due_q[$];
	// output shadows lag the model by two cycles
	soc_bus_pkg::led_t led_d1;
	soc_bus_pkg::led_t led_d2;
	soc_bus_pkg::rst_vec_t rsts_d1;
	soc_bus_pkg::rst_vec_t rsts_d2;
	soc_bus_pkg::clken_t clken_d1;
	soc_bus_pkg::clken_t clken_d2;
	// timer tracking
	logic tick_prev;
	int last_rise;
	int tick_rises;

	`include "fabric_model.svh"

	soc_io_fabric #(
		.SCR_WORDS(SCR_WORDS),
		.SEMA_COUNT(SEMA_COUNT),
		.RST_PULSE_LEN(RST_PULSE_LEN),
		.TICK_PERIOD(TICK_PERIOD),
		.TICK_START(TICK_START),
		.TICK_END(TICK_END)
	) UUT (
		.node_clk(node_clk),
		.rst(rst),
		.req_i(req_i),
		.resp_o(resp_o),
		.led_o(led_o),
		.rsts_o(rsts_o),
		.clken_o(clken_o),
		.tick_irq_o(tick_irq_o)
	);

	always #10 node_clk = ~node_clk;

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

	task automatic show_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		errors++;
	endtask

	// --------------------
	// per cycle checks
	// --------------------
	task automatic check_cycle();
		soc_bus_pkg::bus_resp_t e;
		int due;
		if (led_o !== led_d2)
			show_mismatch("led_o", 128'(led_o), 128'(led_d2));
		if (rsts_o !== rsts_d2)
			show_mismatch("rsts_o", 128'(rsts_o), 128'(rsts_d2));
		if (clken_o !== clken_d2)
			show_mismatch("clken_o", 128'(clken_o), 128'(clken_d2));
		if (resp_o.ack === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("** Error at %0t ns: ack with no request outstanding", $time);
				errors++;
			end
			else begin
				e = exp_q.pop_front();
				due = due_q.pop_front();
				if (cyc != due)
					show_mismatch("ack cycle", 128'(cyc), 128'(due));
				if (resp_o.err !== e.err)
					show_mismatch("resp_o.err", 128'(resp_o.err), 128'(e.err));
				if (resp_o.tid !== e.tid)
					show_mismatch("resp_o.tid", 128'(resp_o.tid), 128'(e.tid));
				if (resp_o.adr !== e.adr)
					show_mismatch("resp_o.adr", 128'(resp_o.adr), 128'(e.adr));
				if (resp_o.dat !== e.dat)
					show_mismatch("resp_o.dat", resp_o.dat, e.dat);
			end
		end
		else begin
			if (resp_o.ack !== 1'b0)
				show_mismatch("resp_o.ack", 128'(resp_o.ack), 128'(0));
			if (resp_o.err !== 1'b0)
				show_mismatch("resp_o.err", 128'(resp_o.err), 128'(0));
			// head is overdue so its ack never came
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				e = exp_q.pop_front();
				due = due_q.pop_front();
				$display("** Error at %0t ns: no ack for request tid 0x%0h", $time, e.tid);
				errors++;
			end
		end
		// rise to rise is one period and the high phase has fixed width
		if (tick_irq_o && !tick_prev) begin
			if (last_rise >= 0 && cyc - last_rise != TICK_PERIOD)
				show_mismatch("tick_irq_o period", 128'(cyc - last_rise), 128'(TICK_PERIOD));
			last_rise = cyc;
			tick_rises++;
		end
		if (!tick_irq_o && tick_prev && cyc - last_rise != TICK_END - TICK_START)
			show_mismatch("tick_irq_o high", 128'(cyc - last_rise),
				128'(TICK_END - TICK_START));
		tick_prev = tick_irq_o;
	endtask

	// one clock of checking then driving on the falling edge
	task automatic run_cycle(input soc_bus_pkg::bus_req_t r);
		soc_bus_pkg::bus_resp_t e;
		@(negedge node_clk);
		cyc++;
		check_cycle();
		e = step_model(r);
		if (r.stb) begin
			exp_q.push_back(e);
			due_q.push_back(cyc + 3);
		end
		led_d2 = led_d1;
		rsts_d2 = rsts_d1;
		clken_d2 = clken_d1;
		led_d1 = m_led;
		rsts_d1 = live_rsts();
		clken_d1 = m_clken;
		req_i = r;
	endtask

	// random request mostly to mapped targets
	function automatic soc_bus_pkg::bus_req_t rand_req(input int tid);
		soc_bus_pkg::bus_req_t r;
		int kind;
		r.stb = $urandom_range(0, 9) < 8;
		r.we = 1'($urandom_range(0, 1));
		r.sel = 16'($urandom);
		r.data = {$urandom, $urandom, $urandom, $urandom};
		r.tid = 8'(tid);
		kind = $urandom_range(0, 19);
		if (kind < 8)
			r.padr = {soc_bus_pkg::SCR_TAG, 24'($urandom)};
		else if (kind < 12)
			r.padr = {soc_bus_pkg::IO_TAG, soc_bus_pkg::SEMA_BANK, 16'($urandom)};
		else if (kind < 15)
			r.padr = {soc_bus_pkg::IO_TAG, soc_bus_pkg::LED_PAGE, 8'($urandom)};
		else if (kind < 17)
			r.padr = {soc_bus_pkg::IO_TAG, soc_bus_pkg::RST_PAGE, 8'($urandom)};
		else
			r.padr = {4'h1, 28'($urandom)};
		return r;
	endfunction

	// --------------------
	// main sequence
	// --------------------
	initial begin
		soc_bus_pkg::bus_req_t r;
		void'($urandom(32'he400fbc0));
		node_clk = 1'b0;
		rst = 1'b1;
		req_i = '0;
		errors = 0;
		cyc = 0;
		tick_prev = 1'b0;
		last_rise = -1;
		tick_rises = 0;
		reset_model();
		led_d1 = m_led;
		led_d2 = m_led;
		rsts_d1 = '0;
		rsts_d2 = '0;
		clken_d1 = m_clken;
		clken_d2 = m_clken;
		repeat (16) @(posedge node_clk);
		@(negedge node_clk);
		rst = 1'b0;
		if (tick_irq_o !== 1'b0)
			show_mismatch("tick_irq_o", 128'(tick_irq_o), 128'(0));
		// full line writes so every scratch read is defined
		for (int i = 0; i < SCR_WORDS; i++) begin
			r.stb = 1'b1;
			r.we = 1'b1;
			r.sel = '1;
			r.padr = {soc_bus_pkg::SCR_TAG, 24'(i * 16)};
			r.data = {$urandom, $urandom, $urandom, $urandom};
			r.tid = 8'(i);
			run_cycle(r);
		end
		for (int i = 0; i < NUM_RAND; i++)
			run_cycle(rand_req(i));
		r = '0;
		repeat (DRAIN) run_cycle(r);
		if (tick_rises == 0) begin
			$display("** Error: timer interrupt never rose");
			errors++;
		end
		$display("errors: %0d, requests issued: %0d", errors, NUM_TXN);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* build.f */
+incdir+bench
hw/soc_bus_pkg.sv
hw/req_decode.sv
hw/scratch_ram.sv
hw/sema_mem.sv
hw/io_regs.sv
hw/tick_timer.sv
hw/resp_merge.sv
hw/soc_io_fabric.sv
bench/soc_io_fabric_tb.sv

/* hw/io_regs.sv */
`timescale 1ns/1ns

module io_regs #(
	parameter int RST_PULSE_LEN = 64
) (
	input logic node_clk,
	input logic rst,
	input soc_bus_pkg::dec_req_t dec_i,
	output soc_bus_pkg::tgt_result_t res_o,
	output soc_bus_pkg::led_t led_o,
	output soc_bus_pkg::rst_vec_t rsts_o,
	output soc_bus_pkg::clken_t clken_o
);

	localparam int CNT_W = $clog2(RST_PULSE_LEN + 1);

	logic led_hit;
	logic rst_hit;
	logic [1:0] lane;
	soc_bus_pkg::word_t wr_word;
	logic [3:0] lane_sel;
	soc_bus_pkg::word_t rd_word;

	soc_bus_pkg::rst_vec_t rst_vec_q;
	logic [CNT_W-1:0] pulse_cnt;
	logic pulse_on;

	// 32 bit lane picked by padr[3:2]
	always_comb begin
		led_hit = dec_i.valid && dec_i.tgt == soc_bus_pkg::TGT_LED;
		rst_hit = dec_i.valid && dec_i.tgt == soc_bus_pkg::TGT_RST;
		lane = dec_i.padr[3:2];
		wr_word = dec_i.data[{lane, 5'd0} +: 32];
		lane_sel = dec_i.sel[{lane, 2'd0} +: 4];
		if (led_hit)
			rd_word = {24'd0, led_o};
		else
			rd_word = {13'd0, clken_o, rsts_o};
	end

	// counter below limit means pulse still running
	assign pulse_on = pulse_cnt < CNT_W'(RST_PULSE_LEN);
	assign rsts_o = pulse_on ? rst_vec_q : '0;

	// --------------------
	// register writes
	// --------------------
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			led_o <= '0;
			rst_vec_q <= '0;
			// saturated, no pulse out of reset
			pulse_cnt <= CNT_W'(RST_PULSE_LEN);
			clken_o <= soc_bus_pkg::CLKEN_RESET;
		end
		else begin
			if (pulse_on)
				pulse_cnt <= pulse_cnt + 1'b1;
			else
				rst_vec_q <= '0;
			if (led_hit && dec_i.we)
				led_o <= wr_word[7:0];
			if (rst_hit && dec_i.we) begin
				// low half restarts the pulse
				if (|lane_sel[1:0]) begin
					rst_vec_q <= wr_word[15:0];
					pulse_cnt <= '0;
				end
				if (|lane_sel[3:2])
					clken_o <= wr_word[18:16];
			end
		end
	end

	// read word copied to every lane
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			res_o <= '0;
		end
		else begin
			res_o.valid <= led_hit || rst_hit;
			if ((led_hit || rst_hit) && !dec_i.we)
				res_o.dat <= {4{rd_word}};
			else
				res_o.dat <= '0;
		end
	end

endmodule

/* hw/req_decode.sv */
`timescale 1ns/1ns

module req_decode (
	input logic node_clk,
	input logic rst,
	input soc_bus_pkg::bus_req_t req_i,
	output soc_bus_pkg::dec_req_t dec_o
);

	logic io_win;
	soc_bus_pkg::tgt_e tgt_d;

	logic valid_q;
	logic we_q;
	soc_bus_pkg::sel_t sel_q;
	soc_bus_pkg::addr_t padr_q;
	soc_bus_pkg::data_t data_q;
	soc_bus_pkg::tid_t tid_q;
	soc_bus_pkg::tgt_e tgt_q;

	// address classify, scratch first then io pages
	always_comb begin
		io_win = req_i.padr[31:20] == soc_bus_pkg::IO_TAG;
		tgt_d = soc_bus_pkg::TGT_NONE;
		if (req_i.padr[31:24] == soc_bus_pkg::SCR_TAG)
			tgt_d = soc_bus_pkg::TGT_SCR;
		else if (io_win && req_i.padr[19:8] == soc_bus_pkg::LED_PAGE)
			tgt_d = soc_bus_pkg::TGT_LED;
		else if (io_win && req_i.padr[19:8] == soc_bus_pkg::RST_PAGE)
			tgt_d = soc_bus_pkg::TGT_RST;
		else if (io_win && req_i.padr[19:16] == soc_bus_pkg::SEMA_BANK)
			tgt_d = soc_bus_pkg::TGT_SEMA;
	end

	// strobe becomes valid one cycle later
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= req_i.stb;
	end

	// payload, qualified by valid downstream
	always_ff @(posedge node_clk) begin
		we_q <= req_i.we;
		sel_q <= req_i.sel;
		padr_q <= req_i.padr;
		data_q <= req_i.data;
		tid_q <= req_i.tid;
		tgt_q <= tgt_d;
	end

	always_comb begin
		dec_o.valid = valid_q;
		dec_o.we = we_q;
		dec_o.sel = sel_q;
		dec_o.padr = padr_q;
		dec_o.data = data_q;
		dec_o.tid = tid_q;
		dec_o.tgt = tgt_q;
	end

endmodule

/* hw/resp_merge.sv */
`timescale 1ns/1ns

module resp_merge (
	input logic node_clk,
	input logic rst,
	input soc_bus_pkg::dec_req_t dec_i,
	input soc_bus_pkg::tgt_result_t scr_i,
	input soc_bus_pkg::tgt_result_t sema_i,
	input soc_bus_pkg::tgt_result_t io_i,
	output soc_bus_pkg::bus_resp_t resp_o
);

	// request tag delayed to match target latency
	logic valid_d;
	logic we_d;
	soc_bus_pkg::tid_t tid_d;
	soc_bus_pkg::addr_t adr_d;

	logic any_hit;
	soc_bus_pkg::data_t or_dat;

	logic ack_q;
	logic err_q;
	soc_bus_pkg::tid_t tid_q;
	soc_bus_pkg::addr_t adr_q;
	soc_bus_pkg::data_t dat_q;

	// --------------------
	// tag alignment
	// --------------------
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst)
			valid_d <= 1'b0;
		else
			valid_d <= dec_i.valid;
	end

	always_ff @(posedge node_clk) begin
		we_d <= dec_i.we;
		tid_d <= dec_i.tid;
		adr_d <= dec_i.padr;
	end

	// idle targets give zero, so a plain OR merges
	always_comb begin
		any_hit = scr_i.valid | sema_i.valid | io_i.valid;
		or_dat = scr_i.dat | sema_i.dat | io_i.dat;
	end

	// --------------------
	// response register
	// --------------------
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end
		else begin
			ack_q <= valid_d;
			// nobody answered, unmapped address
			err_q <= valid_d && !any_hit;
		end
	end

	always_ff @(posedge node_clk) begin
		tid_q <= tid_d;
		adr_q <= adr_d;
		if (!any_hit)
			dat_q <= '1;
		else if (we_d)
			dat_q <= '0;
		else
			dat_q <= or_dat;
	end

	always_comb begin
		resp_o.ack = ack_q;
		resp_o.err = err_q;
		resp_o.tid = tid_q;
		resp_o.adr = adr_q;
		resp_o.dat = dat_q;
	end

endmodule

/* hw/scratch_ram.sv */
`timescale 1ns/1ns

module scratch_ram #(
	parameter int SCR_WORDS = 256
) (
	input logic node_clk,
	input logic rst,
	input soc_bus_pkg::dec_req_t dec_i,
	output soc_bus_pkg::tgt_result_t res_o
);

	localparam int IDX_W = $clog2(SCR_WORDS);

	// one 128 bit line per entry
	soc_bus_pkg::data_t mem [SCR_WORDS];

	logic hit;
	logic [IDX_W-1:0] idx;

	// line index from bits above the byte offset, wraps at depth
	always_comb begin
		hit = dec_i.valid && dec_i.tgt == soc_bus_pkg::TGT_SCR;
		idx = dec_i.padr[4 +: IDX_W];
	end

	// --------------------
	// byte lane writes
	// --------------------
	always_ff @(posedge node_clk) begin
		if (hit && dec_i.we) begin
			for (int i = 0; i < 16; i++) begin
				if (dec_i.sel[i])
					mem[idx][i*8 +: 8] <= dec_i.data[i*8 +: 8];
			end
		end
	end

	// --------------------
	// result register
	// --------------------
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			res_o <= '0;
		end
		else begin
			res_o.valid <= hit;
			// whole line on reads, zero otherwise
			if (hit && !dec_i.we)
				res_o.dat <= mem[idx];
			else
				res_o.dat <= '0;
		end
	end

endmodule

/* hw/sema_mem.sv */
`timescale 1ns/1ns

module sema_mem #(
	parameter int SEMA_COUNT = 256
) (
	input logic node_clk,
	input logic rst,
	input soc_bus_pkg::dec_req_t dec_i,
	output soc_bus_pkg::tgt_result_t res_o
);

	localparam int SIDX_W = $clog2(SEMA_COUNT);

	logic [SEMA_COUNT-1:0] sema_q;
	logic hit;
	logic [SIDX_W-1:0] idx;
	soc_bus_pkg::word_t rd_word;

	// one semaphore per 32 bit word
	always_comb begin
		hit = dec_i.valid && dec_i.tgt == soc_bus_pkg::TGT_SEMA;
		idx = dec_i.padr[2 +: SIDX_W];
		rd_word = {31'd0, sema_q[idx]};
	end

	// read is test-and-set, write releases
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			sema_q <= '0;
			res_o <= '0;
		end
		else begin
			res_o.valid <= hit;
			res_o.dat <= '0;
			if (hit) begin
				if (dec_i.we) begin
					sema_q[idx] <= 1'b0;
				end
				else begin
					// old state out, then taken
					res_o.dat <= {4{rd_word}};
					sema_q[idx] <= 1'b1;
				end
			end
		end
	end

endmodule

/* hw/soc_bus_pkg.sv */
package soc_bus_pkg;

	// --------------------
	// plain vector types
	// --------------------

	// physical address
	typedef logic [31:0] addr_t;
	// one bus line, four io words
	typedef logic [127:0] data_t;
	typedef logic [31:0] word_t;
	// one bit per byte lane
	typedef logic [15:0] sel_t;
	typedef logic [7:0] tid_t;
	typedef logic [7:0] led_t;
	// per-node reset bits
	typedef logic [15:0] rst_vec_t;
	typedef logic [2:0] clken_t;

	// --------------------
	// target classes
	// --------------------
	typedef enum logic [2:0] {
		TGT_NONE = 3'd0,
		TGT_SCR = 3'd1,
		TGT_LED = 3'd2,
		TGT_RST = 3'd3,
		TGT_SEMA = 3'd4
	} tgt_e;

	// cpu side request, stb marks a live cycle
	typedef struct packed {
		logic stb;
		logic we;
		sel_t sel;
		addr_t padr;
		data_t data;
		tid_t tid;
	} bus_req_t;

	// response, ack is a single cycle pulse
	typedef struct packed {
		logic ack;
		logic err;
		tid_t tid;
		addr_t adr;
		data_t dat;
	} bus_resp_t;

	// request after address decode
	typedef struct packed {
		logic valid;
		logic we;
		sel_t sel;
		addr_t padr;
		data_t data;
		tid_t tid;
		tgt_e tgt;
	} dec_req_t;

	// one target's answer, zero when idle
	typedef struct packed {
		logic valid;
		data_t dat;
	} tgt_result_t;

	// --------------------
	// address map
	// --------------------
	localparam logic [7:0] SCR_TAG = 8'hFF;
	localparam logic [11:0] IO_TAG = 12'hFD0;
	// pages below sit inside the io window
	localparam logic [11:0] LED_PAGE = 12'hFFF;
	localparam logic [11:0] RST_PAGE = 12'hFFC;
	localparam logic [3:0] SEMA_BANK = 4'h5;
	// node clocks 1 and 2 on out of reset
	localparam clken_t CLKEN_RESET = 3'b110;

endpackage

/* hw/soc_io_fabric.sv */
`timescale 1ns/1ns

module soc_io_fabric #(
	parameter int SCR_WORDS = 256,
	parameter int SEMA_COUNT = 256,
	parameter int RST_PULSE_LEN = 64,
	parameter int TICK_PERIOD = 1000000,
	parameter int TICK_START = 150,
	parameter int TICK_END = 200
) (
	input logic node_clk,
	input logic rst,
	input soc_bus_pkg::bus_req_t req_i,
	output soc_bus_pkg::bus_resp_t resp_o,
	output soc_bus_pkg::led_t led_o,
	output soc_bus_pkg::rst_vec_t rsts_o,
	output soc_bus_pkg::clken_t clken_o,
	output logic tick_irq_o
);

	soc_bus_pkg::dec_req_t dec_req;
	soc_bus_pkg::tgt_result_t scr_res;
	soc_bus_pkg::tgt_result_t sema_res;
	soc_bus_pkg::tgt_result_t io_res;

	// --------------------
	// stage 1, decode
	// --------------------
	req_decode u_dec (
		.node_clk(node_clk),
		.rst(rst),
		.req_i(req_i),
		.dec_o(dec_req)
	);

	// --------------------
	// stage 2, targets
	// --------------------
	scratch_ram #(.SCR_WORDS(SCR_WORDS)) u_scr (
		.node_clk(node_clk),
		.rst(rst),
		.dec_i(dec_req),
		.res_o(scr_res)
	);

	sema_mem #(.SEMA_COUNT(SEMA_COUNT)) u_sema (
		.node_clk(node_clk),
		.rst(rst),
		.dec_i(dec_req),
		.res_o(sema_res)
	);

	// led port and reset/clock enable page
	io_regs #(.RST_PULSE_LEN(RST_PULSE_LEN)) u_io (
		.node_clk(node_clk),
		.rst(rst),
		.dec_i(dec_req),
		.res_o(io_res),
		.led_o(led_o),
		.rsts_o(rsts_o),
		.clken_o(clken_o)
	);

	// stage 3, merge and respond
	resp_merge u_merge (
		.node_clk(node_clk),
		.rst(rst),
		.dec_i(dec_req),
		.scr_i(scr_res),
		.sema_i(sema_res),
		.io_i(io_res),
		.resp_o(resp_o)
	);

	// periodic interrupt, independent of the bus
	tick_timer #(
		.TICK_PERIOD(TICK_PERIOD),
		.TICK_START(TICK_START),
		.TICK_END(TICK_END)
	) u_tick (
		.node_clk(node_clk),
		.rst(rst),
		.tick_irq_o(tick_irq_o)
	);

endmodule

/* hw/tick_timer.sv */
`timescale 1ns/1ns

module tick_timer #(
	parameter int TICK_PERIOD = 1000000,
	parameter int TICK_START = 150,
	parameter int TICK_END = 200
) (
	input logic node_clk,
	input logic rst,
	output logic tick_irq_o
);

	localparam int TCNT_W = $clog2(TICK_PERIOD + 1);

	logic [TCNT_W-1:0] tick_cnt;

	// count runs 1..TICK_PERIOD
	always_ff @(posedge node_clk, posedge rst) begin
		if (rst) begin
			tick_cnt <= TCNT_W'(1);
			tick_irq_o <= 1'b0;
		end
		else begin
			if (tick_cnt == TCNT_W'(TICK_PERIOD))
				tick_cnt <= TCNT_W'(1);
			else
				tick_cnt <= tick_cnt + 1'b1;
			// high window between start and end counts
			if (tick_cnt == TCNT_W'(TICK_START))
				tick_irq_o <= 1'b1;
			else if (tick_cnt == TCNT_W'(TICK_END))
				tick_irq_o <= 1'b0;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module soc_io_fabric_tb -f build.f \
	-o soc_io_fabric_sim \
	&& ./obj_dir/soc_io_fabric_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^Test OK$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
